// File: flist.f
+incdir+include
hdl/icache_types_pkg.sv
hdl/icache_ctrl_pkg.sv
hdl/icache_stage_if.sv
hdl/icache_req_stage.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

// File: hdl/icache_ctrl_pkg.sv
`default_nettype none

package icache_ctrl_pkg;

    typedef enum logic [1:0] {
        REQ_IDLE,       // waiting for cpu_req
        REQ_LOOKUP,     // start sent, waiting for done
        REQ_ACK,        // cpu_ack high until cpu_req drops
        REQ_RELEASE     // one idle cycle after ack falls
    } req_state_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_MEM_REQ,     // mem_req high, waiting for mem_ack
        RF_MEM_RELEASE, // waiting for mem_ack to fall
        RF_DONE
    } refill_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_lookup (
    input  wire       clk,
    input  wire       reset,
    lookup_if.back    lk,
    refill_if.cache   rf
);
    import icache_types_pkg::*;

    typedef lru_age_t [`ICACHE_WAYS-1:0] age_row_t;

    tag_t  tag_mem  [`ICACHE_SETS][`ICACHE_WAYS];
    word_t data_mem [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
    lru_age_t [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] age_q;

    index_t idx, fill_idx;
    tag_t   tag;
    logic [`ICACHE_WAYS-1:0] way_hit;
    way_t   hit_way, victim, vic_q;
    logic   found;
    logic   pend;           // miss outstanding, waiting for fill
    logic   done_q, miss_q, hit_q;
    word_t  data_q;
    addr_t  miss_addr_q;

    assign idx          = addr_index(lk.addr);
    assign tag          = addr_tag(lk.addr);
    assign fill_idx     = addr_index(miss_addr_q);
    assign lk.done      = done_q;
    assign lk.data      = data_q;
    assign lk.hit       = hit_q;
    assign rf.miss      = miss_q;
    assign rf.miss_addr = miss_addr_q;

    // accessed way goes to 0, younger ways age by one
    function automatic age_row_t touch(age_row_t row, way_t way, lru_age_t old_age);
        age_row_t nxt;
        nxt = row;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (w != way && row[w] < old_age) nxt[w] = row[w] + 2'd1;
        end
        nxt[way] = '0;
        return nxt;
    endfunction

    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (valid_q[idx][w] && tag_mem[idx][w] == tag) begin
                way_hit[w] = 1'b1;
                hit_way    = way_t'(w);
            end
        end
    end

    always_comb begin
        victim = '0;
        found  = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!found && !valid_q[idx][w]) begin   // lowest invalid way first
                victim = way_t'(w);
                found  = 1'b1;
            end
        end
        if (!found) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (age_q[idx][w] == 2'd3) victim = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
            age_q   <= '0;
            pend    <= 1'b0;
            done_q  <= 1'b0;
            miss_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            miss_q <= 1'b0;
            if (lk.start) begin
                if (|way_hit) begin
                    done_q     <= 1'b1;
                    age_q[idx] <= touch(age_q[idx], hit_way, age_q[idx][hit_way]);
                end else begin
                    miss_q <= 1'b1;
                    pend   <= 1'b1;
                end
            end else if (pend && rf.fill) begin
                pend                    <= 1'b0;
                done_q                  <= 1'b1;
                valid_q[fill_idx][vic_q] <= 1'b1;
                // an empty way counts as oldest so every other way ages
                age_q[fill_idx] <= touch(age_q[fill_idx], vic_q,
                    valid_q[fill_idx][vic_q] ? age_q[fill_idx][vic_q] : 2'd3);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.start) begin
            vic_q       <= victim;
            miss_addr_q <= lk.addr;
            hit_q       <= |way_hit;
            data_q      <= data_mem[idx][hit_way];
        end else if (pend && rf.fill) begin
            tag_mem[fill_idx][vic_q]  <= addr_tag(miss_addr_q);
            data_mem[fill_idx][vic_q] <= rf.fill_data;
            data_q                    <= rf.fill_data;  // filled word goes back as a miss
            hit_q                     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  wire                     clk,
    input  wire                     reset,
    refill_if.refill                rf,
    output logic                    mem_req,
    output icache_types_pkg::addr_t mem_addr,
    input  wire                     mem_ack,
    input  icache_types_pkg::word_t mem_data
);
    import icache_types_pkg::*;
    import icache_ctrl_pkg::*;

    refill_state_t state;
    logic          fill_q;
    word_t         fill_data_q;

    assign rf.fill      = fill_q;
    assign rf.fill_data = fill_data_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= RF_IDLE;
            mem_req <= 1'b0;
            fill_q  <= 1'b0;
        end else begin
            fill_q <= 1'b0;
            case (state)
                RF_IDLE: if (rf.miss) begin
                    state   <= RF_MEM_REQ;
                    mem_req <= 1'b1;
                end
                RF_MEM_REQ: if (mem_ack) begin      // slow memory holds us here
                    state   <= RF_MEM_RELEASE;
                    mem_req <= 1'b0;
                    fill_q  <= 1'b1;
                end
                RF_MEM_RELEASE: if (!mem_ack) begin
                    state <= RF_DONE;               // ack low, exchange complete
                end
                RF_DONE: state <= RF_IDLE;
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && rf.miss) begin
            mem_addr <= rf.miss_addr;   // stable for the whole exchange
        end
        if (state == RF_MEM_REQ && mem_ack) begin
            fill_data_q <= mem_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module icache_req_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cpu_req,
    input  icache_types_pkg::addr_t cpu_addr,
    output logic                    cpu_ack,
    output icache_types_pkg::word_t cpu_data,
    output logic                    cpu_hit,
    lookup_if.front                 lk
);
    import icache_types_pkg::*;
    import icache_ctrl_pkg::*;

    req_state_t state;
    addr_t      addr_q;     // held for the whole transaction
    logic       start_q;

    assign lk.start = start_q;
    assign lk.addr  = addr_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= REQ_IDLE;
            start_q <= 1'b0;
            cpu_ack <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                REQ_IDLE: if (cpu_req) begin
                    state   <= REQ_LOOKUP;
                    start_q <= 1'b1;            // single pulse into lookup
                end
                REQ_LOOKUP: if (lk.done) begin
                    state   <= REQ_ACK;
                    cpu_ack <= 1'b1;
                end
                REQ_ACK: if (!cpu_req) begin    // slow cpu simply parks here
                    state   <= REQ_RELEASE;
                    cpu_ack <= 1'b0;
                end
                REQ_RELEASE: state <= REQ_IDLE;
                default:     state <= REQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ_IDLE && cpu_req) begin
            addr_q <= cpu_addr;
        end
        if (state == REQ_LOOKUP && lk.done) begin
            cpu_data <= lk.data;    // response held until the next transaction
            cpu_hit  <= lk.hit;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// request stage <-> lookup stage
interface lookup_if;
    import icache_types_pkg::*;

    logic  start;   // one-cycle pulse, addr held stable
    addr_t addr;
    logic  done;    // one-cycle pulse, data and hit valid with it
    word_t data;
    logic  hit;

    modport front (output start, output addr, input done, input data, input hit);
    modport back (input start, input addr, output done, output data, output hit);
endinterface

// lookup stage <-> refill stage
interface refill_if;
    import icache_types_pkg::*;

    logic  miss;        // one-cycle pulse
    addr_t miss_addr;
    logic  fill;        // one-cycle pulse carrying fill_data
    word_t fill_data;

    modport cache (output miss, output miss_addr, input fill, input fill_data);
    modport refill (input miss, input miss_addr, output fill, output fill_data);
endinterface

`default_nettype wire

// File: hdl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                     clk,
    input  wire                     reset,
    // cpu side
    input  wire                     cpu_req,
    input  icache_types_pkg::addr_t cpu_addr,
    output logic                    cpu_ack,
    output icache_types_pkg::word_t cpu_data,
    output logic                    cpu_hit,
    // memory side
    output logic                    mem_req,
    output icache_types_pkg::addr_t mem_addr,
    input  wire                     mem_ack,
    input  icache_types_pkg::word_t mem_data
);

    lookup_if lk_bus ();
    refill_if rf_bus ();

    icache_req_stage u_req (
        .clk      (clk),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .cpu_ack  (cpu_ack),
        .cpu_data (cpu_data),
        .cpu_hit  (cpu_hit),
        .lk       (lk_bus.front)
    );

    icache_lookup u_lookup (
        .clk   (clk),
        .reset (reset),
        .lk    (lk_bus.back),
        .rf    (rf_bus.cache)
    );

    icache_refill u_refill (
        .clk      (clk),
        .reset    (reset),
        .rf       (rf_bus.refill),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

endmodule

`default_nettype wire

// File: hdl/icache_types_pkg.sv
`default_nettype none

package icache_types_pkg;

    `include "icache_params.svh"

    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;         // byte address
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
    typedef logic [31:0] word_t;                           // instruction word
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
    typedef logic [1:0] lru_age_t;                         // 0 newest, 3 oldest

    // upper bits above index form the tag
    function automatic tag_t addr_tag(addr_t a);
        return a[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    endfunction

    // set index sits just above the two byte offset bits
    function automatic index_t addr_index(addr_t a);
        return a[`ICACHE_INDEX_BITS+1:2];
    endfunction

endpackage

`default_nettype wire

// File: include/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry

`define ICACHE_WAYS 4          // ways per set
`define ICACHE_SETS 64         // sets, one word per line

// byte address split: tag | index | byte offset (ignored)

`define ICACHE_ADDR_BITS 32    // full byte address
`define ICACHE_INDEX_BITS 6    // address bits 7..2
`define ICACHE_TAG_BITS 24     // address bits 31..8

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module icache_tb -o sim_icache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_icache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: verification/icache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
    input wire                     clk,
    input wire                     reset,
    input wire                     cpu_req,
    input wire                     cpu_ack,
    input wire                     cpu_hit,
    input wire                     mem_req,
    input wire                     mem_ack,
    input icache_types_pkg::addr_t mem_addr
);

    logic mem_seen;     // mem_req seen since the last ack

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem_seen <= 1'b0;
        end else if (mem_req) begin
            mem_seen <= 1'b1;
        end else if (cpu_ack) begin
            mem_seen <= 1'b0;
        end
    end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!reset)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack was seen");

    a_mem_addr_stable: assert property (@(posedge clk) disable iff (!reset)
        mem_req && $past(mem_req) |-> $stable(mem_addr))
        else $error("mem_addr changed while mem_req was high");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
        !cpu_req && !cpu_ack |=> !cpu_ack)
        else $error("cpu_ack rose while cpu_req was low");

    a_hit_no_mem: assert property (@(posedge clk) disable iff (!reset)
        $rose(cpu_ack) && cpu_hit |-> !mem_seen)
        else $error("memory was requested during a transaction that ended as a hit");

endmodule

`default_nettype wire

// File: verification/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tb;
    import icache_types_pkg::*;

    localparam int NUM_TRANS      = 320;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 40 + 200;

    logic  clk;
    logic  reset;
    logic  cpu_req;
    addr_t cpu_addr;
    logic  cpu_ack;
    word_t cpu_data;
    logic  cpu_hit;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_ack;
    word_t mem_data;

    logic [31:0] rng = 32'd94;
    int    errors    = 0;
    int    n_trans   = 0;
    int    mem_xfers = 0;  // completed memory exchanges
    int    acks      = 0;
    int    mem_delay;
    logic  ack_prev  = 1'b0;
    logic  exp_hit_q[$];
    word_t exp_data_q[$];

    // reference cache state
    logic  ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
    tag_t  ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    int    ref_age   [`ICACHE_SETS][`ICACHE_WAYS];

    icache_top uut (
        .clk      (clk),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .cpu_ack  (cpu_ack),
        .cpu_data (cpu_data),
        .cpu_hit  (cpu_hit),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    bind icache_top icache_chk u_chk (
        .clk      (clk),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .cpu_ack  (cpu_ack),
        .cpu_hit  (cpu_hit),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .mem_addr (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // memory contents, byte offset bits do not matter
    function automatic word_t mem_word(addr_t a);
        return ({2'b00, a[31:2]} * 32'h9e37_79b1) ^ {a[9:2], a[31:10], 2'b11};
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t s);
        return {t, s, 2'b00};
    endfunction

    // predicts the hit flag and updates the model's tags, valid bits and ages
    function automatic logic ref_access(addr_t a);
        index_t s;
        tag_t   t;
        int     sel;
        int     old_age;
        logic   hit;
        s   = a[7:2];
        t   = a[31:8];
        hit = 1'b0;
        sel = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                hit = 1'b1;
                sel = w;
            end
        end
        if (!hit) begin
            for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[s][w]) sel = w;  // lowest empty way wins
            end
            if (sel < 0) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (ref_age[s][w] == 3) sel = w;
                end
            end
            old_age = ref_valid[s][sel] ? ref_age[s][sel] : 3;
            ref_valid[s][sel] = 1'b1;
            ref_tag[s][sel]   = t;
        end else begin
            old_age = ref_age[s][sel];
        end
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (w != sel && ref_age[s][w] < old_age) ref_age[s][w] = ref_age[s][w] + 1;
        end
        ref_age[s][sel] = 0;
        return hit;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // one cpu transaction, hold = extra cycles cpu_req stays high after ack
    task automatic access(input addr_t a, input int hold);
        logic exp_hit;
        int   cyc;
        int   xfers0;
        exp_hit = ref_access(a);
        exp_hit_q.push_back(exp_hit);
        exp_data_q.push_back(mem_word(a));
        xfers0   = mem_xfers;
        cpu_addr = a;
        cpu_req  = 1'b1;
        cyc      = 0;
        while (!cpu_ack) begin
            tick();
            cyc++;
        end
        if (exp_hit) check_value("hit_latency", 32'(cyc), 32'd3);
        check_value("mem_exchanges", 32'(mem_xfers - xfers0), exp_hit ? 32'd0 : 32'd1);
        repeat (hold) begin
            tick();
            check_value("cpu_ack", 32'(cpu_ack), 32'd1);
            check_value("mem_req", 32'(mem_req), 32'd0);
        end
        cpu_req = 1'b0;
        while (cpu_ack) tick();
        tick();     // request stage passes through its release cycle
        n_trans++;
    endtask

    // response checker
    always begin
        tick();
        if (cpu_ack && !ack_prev) begin
            if (exp_hit_q.size() == 0) begin
                errors++;
                $display("cpu_ack rose with no open request");
            end else begin
                check_value("cpu_hit", 32'(cpu_hit), 32'(exp_hit_q.pop_front()));
                check_value("cpu_data", cpu_data, exp_data_q.pop_front());
                acks++;
            end
        end
        ack_prev = cpu_ack;
    end

    // memory model with random answer delay
    always begin
        tick();
        if (mem_req && !mem_ack) begin
            check_value("mem_addr", {mem_addr[31:2], 2'b00}, {cpu_addr[31:2], 2'b00});
            mem_delay = int'(next_rand() % 32'd6);
            repeat (mem_delay) tick();
            mem_data = mem_word(mem_addr);
            mem_ack  = 1'b1;
            mem_xfers++;
            while (mem_req) tick();
            mem_ack = 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles, a handshake never completed",
                 TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int acks0;
        reset    = 1'b0;
        cpu_req  = 1'b0;
        cpu_addr = '0;
        mem_ack  = 1'b0;
        mem_data = '0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = 0;
            end
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b1;
        tick();

        access(32'h0001_2340, 0);   // cold miss
        access(32'h0001_2340, 0);   // same line hits
        for (int t = 1; t <= 5; t++) access(make_addr(24'(t), 6'd5), 0);
        for (int t = 1; t <= 4; t++) access(make_addr(24'(t), 6'd5), 0);

        // refresh the oldest way, so the next miss evicts another one
        for (int t = 17; t <= 20; t++) access(make_addr(24'(t), 6'd9), 0);
        access(make_addr(24'd17, 6'd9), 0);
        access(make_addr(24'd21, 6'd9), 0);
        access(make_addr(24'd17, 6'd9), 0);
        access(make_addr(24'd18, 6'd9), 0);

        repeat (300) begin
            access(make_addr(24'(next_rand() % 32'd6), 6'(32'd12 + next_rand() % 32'd3)), 0);
        end

        acks0 = acks;
        access(make_addr(24'd17, 6'd9), 5);
        check_value("ack_count", 32'(acks - acks0), 32'd1);

        repeat (4) tick();
        if (exp_hit_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_hit_q.size());
        end
        $display("errors: %0d, transactions: %0d, memory exchanges: %0d",
                 errors, n_trans, mem_xfers);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
